// File: logic/regfile_defs.svh
// ################################################
// Register file geometry and build mode macros
// ################################################

`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// Architectural registers in total
`define REGFILE_NUM_REGS 64

// Banks, interleaved on the low index bits
`define REGFILE_NUM_BANKS 4

// Width of one register
`define REGFILE_DATA_WIDTH 32

// Tagged read ports
`define REGFILE_NUM_READ_PORTS 2

// 1 gives every bank a separate write port
`define REGFILE_DUAL_PORT 0

`endif

// File: logic/regfile_pkg.sv
// ################################################
// Register file width types and bus structs
// ################################################

`default_nettype none

`include "regfile_defs.svh"

package regfile_pkg;

    // Register payload
    typedef logic [`REGFILE_DATA_WIDTH-1:0] data_t;

    // Architectural register index
    typedef logic [$clog2(`REGFILE_NUM_REGS)-1:0] reg_addr_t;

    // Bank select, low bits of the index
    typedef logic [$clog2(`REGFILE_NUM_BANKS)-1:0] bank_idx_t;

    // Entry within a bank, high bits of the index
    typedef logic [$clog2(`REGFILE_NUM_REGS/`REGFILE_NUM_BANKS)-1:0] bank_addr_t;

    // Read port tag
    typedef logic [$clog2(`REGFILE_NUM_READ_PORTS)-1:0] port_idx_t;

    // ################################################
    // Structs
    // ################################################

    // Write request from outside, 38 bits
    typedef struct packed {
        reg_addr_t addr;
        data_t     data;
    } wr_req_t;

    // Write request into one bank, 36 bits
    typedef struct packed {
        bank_addr_t addr;
        data_t      data;
    } bank_wr_t;

    // Tagged read response, 33 bits
    typedef struct packed {
        port_idx_t tag;
        data_t     data;
    } rd_rsp_t;

endpackage

`default_nettype wire

// File: logic/regfile_sram.sv
// ################################################
// Behavioral SRAM, one-cycle read latency
// One or two ports, contents start as all ones
// ################################################

`timescale 1ns/10ps
`default_nettype none

module regfile_sram #(
    parameter int unsigned NumWords = 16,
    parameter int unsigned NumPorts = 1
) (
    input  wire logic                                   clk_i,
    input  wire logic                  [NumPorts-1:0]   req_i,
    input  wire logic                  [NumPorts-1:0]   we_i,
    input  wire regfile_pkg::bank_addr_t [NumPorts-1:0] addr_i,
    input  wire regfile_pkg::data_t      [NumPorts-1:0] wdata_i,
    output      regfile_pkg::data_t      [NumPorts-1:0] rdata_o
);
    import regfile_pkg::*;

    // ################################################
    // Storage
    // ################################################

    // Power-up pattern of all ones
    data_t mem_q [NumWords] = '{default: '1};

    // Read data register per port
    data_t [NumPorts-1:0] rdata_q;

    // Port 0 first, so port 1 wins a write collision in simulation
    always_ff @(posedge clk_i) begin
        for (int unsigned p = 0; p < NumPorts; p++) begin
            if (req_i[p]) begin
                if (we_i[p]) begin
                    mem_q[addr_i[p]] <= wdata_i[p];
                end else begin
                    // Read before write on the same edge
                    rdata_q[p] <= mem_q[addr_i[p]];
                end
            end
        end
    end

    assign rdata_o = rdata_q;

    // ################################################
    // Assertions
    // ################################################

    if (NumPorts == 2) begin : gen_collision_check
        // Writes on both ports to one entry have no defined winner
        a_no_write_collision: assert property (@(posedge clk_i)
            (req_i[1] && we_i[1] && req_i[0] && we_i[0]) |-> (addr_i[0] != addr_i[1]))
            else $error("regfile_sram: both ports write entry %0d", addr_i[0]);
    end

    initial begin
        a_port_count: assert (NumPorts == 1 || NumPorts == 2)
            else $error("regfile_sram: NumPorts must be 1 or 2");
    end

endmodule

`default_nettype wire

// File: logic/register_file_bank.sv
// ################################################
// One register file bank
// Write-priority port sharing in front of the SRAM
// ################################################

`timescale 1ns/10ps
`default_nettype none

`include "regfile_defs.svh"

module register_file_bank #(
    // Separate read and write SRAM ports
    parameter bit DualPort = 1'b0
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,

    // Write port, always accepted
    input  wire logic                    write_valid_i,
    input  wire regfile_pkg::bank_wr_t   write_req_i,

    // Read request
    input  wire logic                    read_valid_i,
    output      logic                    read_ready_o,
    input  wire regfile_pkg::bank_addr_t read_addr_i,
    input  wire regfile_pkg::port_idx_t  read_tag_i,

    // Read response, one cycle after the handshake
    output      logic                    read_valid_o,
    output      regfile_pkg::rd_rsp_t    read_rsp_o
);
    import regfile_pkg::*;

    localparam int unsigned NumPorts = DualPort ? 2 : 1;
    localparam int unsigned NumWords = `REGFILE_NUM_REGS / `REGFILE_NUM_BANKS;

    // ################################################
    // Signals
    // ################################################

    // SRAM port bundle
    logic       [NumPorts-1:0] mem_req;
    logic       [NumPorts-1:0] mem_we;
    bank_addr_t [NumPorts-1:0] mem_addr;
    data_t      [NumPorts-1:0] mem_wdata;
    data_t      [NumPorts-1:0] mem_rdata;

    // Read started this cycle
    logic      read_valid_d;
    logic      read_valid_q;
    port_idx_t read_tag_q;

    // ################################################
    // Port sharing
    // ################################################

    if (DualPort) begin : gen_dual_port
        // Port 0 only reads
        assign mem_req[0]   = read_valid_i;
        assign mem_we[0]    = 1'b0;
        assign mem_addr[0]  = read_addr_i;
        assign mem_wdata[0] = '0;

        // Port 1 only writes
        assign mem_req[1]   = write_valid_i;
        assign mem_we[1]    = 1'b1;
        assign mem_addr[1]  = write_req_i.addr;
        assign mem_wdata[1] = write_req_i.data;

        // No conflict, reads never wait
        assign read_ready_o = 1'b1;
        assign read_valid_d = read_valid_i;
    end else begin : gen_single_port
        always_comb begin
            mem_req      = '0;
            mem_we       = '0;
            mem_addr     = '0;
            mem_wdata    = '0;
            read_ready_o = 1'b1;
            read_valid_d = 1'b0;

            // Write owns the port, read stalls
            if (write_valid_i) begin
                mem_req[0]   = 1'b1;
                mem_we[0]    = 1'b1;
                mem_addr[0]  = write_req_i.addr;
                mem_wdata[0] = write_req_i.data;
                read_ready_o = 1'b0;
            end else if (read_valid_i) begin
                mem_req[0]   = 1'b1;
                mem_addr[0]  = read_addr_i;
                read_valid_d = 1'b1;
            end
        end
    end

    // ################################################
    // Response delay
    // ################################################

    // Valid matches the SRAM latency
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            read_valid_q <= 1'b0;
        end else begin
            read_valid_q <= read_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        read_tag_q <= read_tag_i;
    end

    assign read_valid_o = read_valid_q;
    // Read data always leaves on port 0
    assign read_rsp_o   = '{tag: read_tag_q, data: mem_rdata[0]};

    regfile_sram #(
        .NumWords ( NumWords ),
        .NumPorts ( NumPorts )
    ) u_regfile_sram (
        .clk_i   ( clk_i     ),
        .req_i   ( mem_req   ),
        .we_i    ( mem_we    ),
        .addr_i  ( mem_addr  ),
        .wdata_i ( mem_wdata ),
        .rdata_o ( mem_rdata )
    );

    // Every response traces back to one accepted read
    a_rsp_after_handshake: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        read_valid_o |-> $past(read_valid_i && read_ready_o))
        else $error("register_file_bank: response without a read handshake");

endmodule

`default_nettype wire

// File: logic/bank_read_arbiter.sv
// ################################################
// Round-robin read arbiter for one bank
// ################################################

`timescale 1ns/10ps
`default_nettype none

`include "regfile_defs.svh"

module bank_read_arbiter (
    input  wire logic                                                  clk_i,
    input  wire logic                                                  rst_n_i,

    // Requests from the read ports that target this bank
    input  wire logic                    [`REGFILE_NUM_READ_PORTS-1:0] req_i,
    input  wire regfile_pkg::bank_addr_t [`REGFILE_NUM_READ_PORTS-1:0] addr_i,

    // Bank side
    input  wire logic                                                  ready_i,
    output      logic                    [`REGFILE_NUM_READ_PORTS-1:0] grant_o,
    output      logic                                                  valid_o,
    output      regfile_pkg::bank_addr_t                               addr_o,
    output      regfile_pkg::port_idx_t                                tag_o
);
    import regfile_pkg::*;

    localparam int unsigned NumPorts = `REGFILE_NUM_READ_PORTS;

    // Highest priority port this round
    port_idx_t ptr_q;
    port_idx_t ptr_d;

    // ################################################
    // Selection
    // ################################################

    // First requester at or after the pointer
    always_comb begin
        int unsigned cand;
        grant_o = '0;
        valid_o = 1'b0;
        addr_o  = '0;
        tag_o   = '0;
        for (int unsigned i = 0; i < NumPorts; i++) begin
            cand = (ptr_q + i) % NumPorts;
            if (!valid_o && req_i[cand]) begin
                valid_o       = 1'b1;
                grant_o[cand] = 1'b1;
                addr_o        = addr_i[cand];
                tag_o         = port_idx_t'(cand);
            end
        end
    end

    // Move past the winner on a handshake only
    always_comb begin
        ptr_d = ptr_q;
        if (valid_o && ready_i) begin
            ptr_d = (tag_o == port_idx_t'(NumPorts - 1)) ? '0 : port_idx_t'(tag_o + 1'b1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= ptr_d;
        end
    end

    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(grant_o) && ((grant_o & ~req_i) == '0))
        else $error("bank_read_arbiter: bad grant %b for requests %b", grant_o, req_i);

endmodule

`default_nettype wire

// File: logic/banked_register_file.sv
// ################################################
// Banked register file, top level
// Bank decode, arbitration, response routing
// ################################################

`timescale 1ns/10ps
`default_nettype none

`include "regfile_defs.svh"

module banked_register_file (
    input  wire logic                                                 clk_i,
    input  wire logic                                                 rst_n_i,

    // Write port, accepted whenever valid
    input  wire logic                                                 wr_valid_i,
    input  wire regfile_pkg::wr_req_t                                 wr_req_i,

    // Read request ports
    input  wire logic                   [`REGFILE_NUM_READ_PORTS-1:0] rd_valid_i,
    input  wire regfile_pkg::reg_addr_t [`REGFILE_NUM_READ_PORTS-1:0] rd_addr_i,
    output      logic                   [`REGFILE_NUM_READ_PORTS-1:0] rd_ready_o,

    // Read responses, no back-pressure
    output      logic                   [`REGFILE_NUM_READ_PORTS-1:0] rsp_valid_o,
    output      regfile_pkg::data_t     [`REGFILE_NUM_READ_PORTS-1:0] rsp_data_o
);
    import regfile_pkg::*;

    localparam int unsigned NumPorts = `REGFILE_NUM_READ_PORTS;
    localparam int unsigned NumBanks = `REGFILE_NUM_BANKS;
    localparam int unsigned BankBits = $bits(bank_idx_t);
    localparam int unsigned RegBits  = $bits(reg_addr_t);

    // ################################################
    // Signals
    // ################################################

    // Write decode
    bank_idx_t               wr_bank;
    bank_wr_t                bank_wr;
    logic     [NumBanks-1:0] bank_wr_valid;

    // Read decode per port
    bank_idx_t  [NumPorts-1:0] rd_bank;
    bank_addr_t [NumPorts-1:0] rd_entry;

    // Arbiter to bank
    logic       [NumBanks-1:0][NumPorts-1:0] arb_req;
    logic       [NumBanks-1:0][NumPorts-1:0] arb_grant;
    logic       [NumBanks-1:0]               arb_valid;
    bank_addr_t [NumBanks-1:0]               arb_addr;
    port_idx_t  [NumBanks-1:0]               arb_tag;
    logic       [NumBanks-1:0]               bank_ready;

    // Bank responses and their port match
    logic    [NumBanks-1:0]               bank_rsp_valid;
    rd_rsp_t [NumBanks-1:0]               bank_rsp;
    logic    [NumPorts-1:0][NumBanks-1:0] rsp_hit;

    // ################################################
    // Address decode
    // ################################################

    // Low bits pick the bank, high bits the entry
    assign wr_bank      = wr_req_i.addr[BankBits-1:0];
    assign bank_wr.addr = wr_req_i.addr[RegBits-1:BankBits];
    assign bank_wr.data = wr_req_i.data;

    always_comb begin
        for (int unsigned b = 0; b < NumBanks; b++) begin
            bank_wr_valid[b] = wr_valid_i && (wr_bank == bank_idx_t'(b));
        end
    end

    always_comb begin
        for (int unsigned p = 0; p < NumPorts; p++) begin
            rd_bank[p]  = rd_addr_i[p][BankBits-1:0];
            rd_entry[p] = rd_addr_i[p][RegBits-1:BankBits];
            for (int unsigned b = 0; b < NumBanks; b++) begin
                arb_req[b][p] = rd_valid_i[p] && (rd_bank[p] == bank_idx_t'(b));
            end
        end
    end

    // Port is ready when it won its bank and the bank takes the read
    always_comb begin
        rd_ready_o = '0;
        for (int unsigned p = 0; p < NumPorts; p++) begin
            for (int unsigned b = 0; b < NumBanks; b++) begin
                if (arb_grant[b][p] && bank_ready[b]) begin
                    rd_ready_o[p] = 1'b1;
                end
            end
        end
    end

    // ################################################
    // Arbiters and banks
    // ################################################

    for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
        bank_read_arbiter u_bank_read_arbiter (
            .clk_i   ( clk_i        ),
            .rst_n_i ( rst_n_i      ),
            .req_i   ( arb_req[b]   ),
            .addr_i  ( rd_entry     ),
            .ready_i ( bank_ready[b] ),
            .grant_o ( arb_grant[b] ),
            .valid_o ( arb_valid[b] ),
            .addr_o  ( arb_addr[b]  ),
            .tag_o   ( arb_tag[b]   )
        );

        register_file_bank #(
            .DualPort ( 1'(`REGFILE_DUAL_PORT) )
        ) u_register_file_bank (
            .clk_i         ( clk_i             ),
            .rst_n_i       ( rst_n_i           ),
            .write_valid_i ( bank_wr_valid[b]  ),
            .write_req_i   ( bank_wr           ),
            .read_valid_i  ( arb_valid[b]      ),
            .read_ready_o  ( bank_ready[b]     ),
            .read_addr_i   ( arb_addr[b]       ),
            .read_tag_i    ( arb_tag[b]        ),
            .read_valid_o  ( bank_rsp_valid[b] ),
            .read_rsp_o    ( bank_rsp[b]       )
        );
    end

    // ################################################
    // Response routing
    // ################################################

    // Tag names the port that asked
    always_comb begin
        rsp_valid_o = '0;
        rsp_data_o  = '0;
        for (int unsigned p = 0; p < NumPorts; p++) begin
            for (int unsigned b = 0; b < NumBanks; b++) begin
                rsp_hit[p][b] = bank_rsp_valid[b] && (bank_rsp[b].tag == port_idx_t'(p));
                if (rsp_hit[p][b]) begin
                    rsp_valid_o[p] = 1'b1;
                    rsp_data_o[p]  = bank_rsp[b].data;
                end
            end
        end
    end

    // One accepted read per port and cycle, so at most one bank answers it
    for (genvar p = 0; p < NumPorts; p++) begin : gen_rsp_check
        a_single_responder: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            $onehot0(rsp_hit[p]))
            else $error("banked_register_file: banks %b answer port %0d", rsp_hit[p], p);
    end

endmodule

`default_nettype wire

// File: dv/regfile_checker.sv
// ################################################
// Register file checker: shadow model, expected
// queues per read port and response comparison
// ################################################

`timescale 1ns/10ps
`default_nettype none

`include "regfile_defs.svh"

module regfile_checker (
    input  wire logic                                                 clk_i,
    input  wire logic                                                 rst_n_i,
    input  wire logic                   [8*12-1:0]                    test_name_i,

    // DUT ports, observed only
    input  wire logic                                                 wr_valid_i,
    input  wire regfile_pkg::wr_req_t                                 wr_req_i,
    input  wire logic                   [`REGFILE_NUM_READ_PORTS-1:0] rd_valid_i,
    input  wire regfile_pkg::reg_addr_t [`REGFILE_NUM_READ_PORTS-1:0] rd_addr_i,
    input  wire logic                   [`REGFILE_NUM_READ_PORTS-1:0] rd_ready_i,
    input  wire logic                   [`REGFILE_NUM_READ_PORTS-1:0] rsp_valid_i,
    input  wire regfile_pkg::data_t     [`REGFILE_NUM_READ_PORTS-1:0] rsp_data_i,

    // Running counts
    output int                                                        checks_o,
    output int                                                        mismatches_o,
    output int                                                        strays_o,
    output int                                                        missing_o
);
    import regfile_pkg::*;

    localparam int NumPorts = `REGFILE_NUM_READ_PORTS;
    localparam int NumRegs  = `REGFILE_NUM_REGS;

    // Shadow of the architectural registers
    data_t shadow [NumRegs];

    // Expected data per port, in request order
    data_t expect_q [NumPorts][$];

    // Ports with a read accepted on the last edge
    bit [NumPorts-1:0] due = '0;

    int checks      = 0;
    int mismatches  = 0;
    int strays      = 0;
    int missing     = 0;
    int idle_cycles = 0;

    assign checks_o     = checks;
    assign mismatches_o = mismatches;
    assign strays_o     = strays;
    assign missing_o    = missing;

    // Unwritten registers read as all ones
    initial begin
        for (int r = 0; r < NumRegs; r++) begin
            shadow[r] = '1;
        end
    end

    // Value a read must return, state before the same-edge write
    function automatic data_t reference_read(reg_addr_t addr);
        return shadow[addr];
    endfunction

    // ################################################
    // Compare
    // ################################################

    always @(posedge clk_i) begin
        data_t expected;
        bit    active;
        if (rst_n_i) begin
            active = 1'b0;
            // Responses first, they belong to earlier handshakes
            for (int p = 0; p < NumPorts; p++) begin
                // Each read is answered on the very next edge
                if (due[p] && !rsp_valid_i[p]) begin
                    missing++;
                    $display("Port %0d gave no response one cycle after its read during %0s",
                             p, string'(test_name_i));
                end
                if (rsp_valid_i[p]) begin
                    active = 1'b1;
                    if (expect_q[p].size() == 0) begin
                        strays++;
                        $display("Response on port %0d during %0s with no read outstanding",
                                 p, string'(test_name_i));
                    end else begin
                        expected = expect_q[p].pop_front();
                        checks++;
                        if (rsp_data_i[p] !== expected) begin
                            mismatches++;
                            $display("Fail %0s: port %0d expected %h actual %h",
                                     string'(test_name_i), p, expected, rsp_data_i[p]);
                        end
                    end
                end
            end
            for (int p = 0; p < NumPorts; p++) begin
                due[p] = rd_valid_i[p] && rd_ready_i[p];
                if (due[p]) begin
                    active = 1'b1;
                    expect_q[p].push_back(reference_read(rd_addr_i[p]));
                end
            end
            // Write lands after the same-edge reads were sampled
            if (wr_valid_i) begin
                shadow[wr_req_i.addr] = wr_req_i.data;
            end
            idle_cycles = active ? 0 : idle_cycles + 1;
            // A response is due one cycle after its read
            if (idle_cycles == 2) begin
                for (int p = 0; p < NumPorts; p++) begin
                    if (expect_q[p].size() != 0) begin
                        missing += expect_q[p].size();
                        $display("Port %0d never answered %0d reads during %0s",
                                 p, expect_q[p].size(), string'(test_name_i));
                        expect_q[p].delete();
                    end
                end
            end
        end else begin
            due = '0;
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_banked_register_file.sv
// ################################################
// Testbench for the banked register file
// Clock, reset, queued stimulus, tests, timeout
// ################################################

`timescale 1ns/10ps
`default_nettype none

`include "regfile_defs.svh"

module tb_banked_register_file;
    import regfile_pkg::*;

    localparam int NumPorts  = `REGFILE_NUM_READ_PORTS;
    localparam int NumRegs   = `REGFILE_NUM_REGS;
    localparam int NumBanks  = `REGFILE_NUM_BANKS;
    localparam bit DualPort  = 1'(`REGFILE_DUAL_PORT);
    // Roughly 4000 cycles of tests plus margin
    localparam int MaxCycles = 6000;

    logic clk;
    logic rst_n;
    logic                       wr_valid;
    wr_req_t                    wr_req;
    logic      [NumPorts-1:0]   rd_valid;
    reg_addr_t [NumPorts-1:0]   rd_addr;
    logic      [NumPorts-1:0]   rd_ready;
    logic      [NumPorts-1:0]   rsp_valid;
    data_t     [NumPorts-1:0]   rsp_data;
    logic      [8*12-1:0]       test_name;

    // Pending requests, the driver holds each until accepted
    reg_addr_t rd_queue [NumPorts][$];
    wr_req_t   wr_queue [$];

    int cur_wait [NumPorts];
    int max_wait [NumPorts];
    int busy_accepts = 0;
    int cycle_count  = 0;
    int tb_errors    = 0;
    int prev_checks  = 0;
    int prev_errors  = 0;
    int checks;
    int mismatches;
    int strays;
    int missing;

    banked_register_file u_banked_register_file (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .wr_valid_i  ( wr_valid  ),
        .wr_req_i    ( wr_req    ),
        .rd_valid_i  ( rd_valid  ),
        .rd_addr_i   ( rd_addr   ),
        .rd_ready_o  ( rd_ready  ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_data_o  ( rsp_data  )
    );

    regfile_checker u_regfile_checker (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .test_name_i  ( test_name  ),
        .wr_valid_i   ( wr_valid   ),
        .wr_req_i     ( wr_req     ),
        .rd_valid_i   ( rd_valid   ),
        .rd_addr_i    ( rd_addr    ),
        .rd_ready_i   ( rd_ready   ),
        .rsp_valid_i  ( rsp_valid  ),
        .rsp_data_i   ( rsp_data   ),
        .checks_o     ( checks     ),
        .mismatches_o ( mismatches ),
        .strays_o     ( strays     ),
        .missing_o    ( missing    )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ################################################
    // Driver
    // ################################################

    always @(posedge clk) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
            rd_valid <= '0;
        end else begin
            for (int p = 0; p < NumPorts; p++) begin
                if (rd_valid[p] && rd_ready[p]) begin
                    // Read taken by a bank that also takes a write
                    if (wr_valid && bank_idx_t'(wr_req.addr) == bank_idx_t'(rd_addr[p])) begin
                        busy_accepts++;
                    end
                    void'(rd_queue[p].pop_front());
                    cur_wait[p] = 0;
                end else if (rd_valid[p]) begin
                    cur_wait[p]++;
                    if (cur_wait[p] > max_wait[p]) begin
                        max_wait[p] = cur_wait[p];
                    end
                end
                if (rd_queue[p].size() != 0) begin
                    rd_valid[p] <= 1'b1;
                    rd_addr[p]  <= rd_queue[p][0];
                end else begin
                    rd_valid[p] <= 1'b0;
                end
            end
            // Writes are accepted every cycle
            if (wr_queue.size() != 0) begin
                wr_valid <= 1'b1;
                wr_req   <= wr_queue.pop_front();
            end else begin
                wr_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MaxCycles) begin
            $display("Run stopped: no end after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic queue_read(int port, int addr);
        rd_queue[port].push_back(reg_addr_t'(addr));
    endtask

    task automatic queue_write(int addr, data_t data);
        wr_req_t req;
        req.addr = reg_addr_t'(addr);
        req.data = data;
        wr_queue.push_back(req);
    endtask

    // Until nothing is pending, then let responses land
    task automatic drain();
        bit busy;
        do begin
            @(negedge clk);
            busy = wr_valid || (rd_valid != '0) || (wr_queue.size() != 0);
            for (int p = 0; p < NumPorts; p++) begin
                if (rd_queue[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end while (busy);
        repeat (3) @(posedge clk);
    endtask

    task automatic clear_waits();
        for (int p = 0; p < NumPorts; p++) begin
            max_wait[p] = 0;
            cur_wait[p] = 0;
        end
        busy_accepts = 0;
    endtask

    task automatic report_test();
        int errors;
        @(negedge clk);
        errors = mismatches + strays + missing + tb_errors;
        $display("Test %0s: %0d checks, %0d errors", string'(test_name),
                 checks - prev_checks, errors - prev_errors);
        prev_checks = checks;
        prev_errors = errors;
    endtask

    // ################################################
    // Tests
    // ################################################

    initial begin
        int unsigned seed_val;
        seed_val  = $urandom(32'h000b_beea);
        rst_n     = 1'b0;
        wr_valid  = 1'b0;
        wr_req    = '0;
        rd_valid  = '0;
        rd_addr   = '0;
        test_name = "reset_idle";
        clear_waits();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet bus, then every register in its power-up state
        repeat (20) @(posedge clk);
        for (int i = 0; i < NumRegs / 2; i++) begin
            queue_read(0, i);
            queue_read(1, NumRegs - 1 - i);
        end
        drain();
        report_test();

        test_name = "write_read";
        for (int i = 0; i < NumRegs; i++) begin
            queue_write(i, {8'(i), 24'($urandom)});
        end
        drain();
        for (int i = 0; i < NumRegs; i++) begin
            queue_read(0, i);
            queue_read(1, i);
        end
        drain();
        report_test();

        // Both ports hammer bank 2 on different entries
        test_name = "bank_share";
        clear_waits();
        for (int i = 0; i < 100; i++) begin
            queue_read(0, (i % 16) * NumBanks + 2);
            queue_read(1, ((i + 8) % 16) * NumBanks + 2);
        end
        drain();
        for (int p = 0; p < NumPorts; p++) begin
            if (max_wait[p] > 1) begin
                tb_errors++;
                $display("Port %0d waited %0d cycles in bank_share, at most 1 allowed",
                         p, max_wait[p]);
            end
        end
        report_test();

        // Write stream into bank 3, last write goes to register 3
        test_name = "write_block";
        clear_waits();
        for (int i = 0; i < 24; i++) begin
            queue_write(((23 - i) % 16) * NumBanks + 3, $urandom);
        end
        for (int i = 0; i < 4; i++) begin
            queue_read(0, 3);
            queue_read(1, 7);
        end
        drain();
        if (!DualPort && busy_accepts != 0) begin
            tb_errors++;
            $display("%0d reads were accepted by a bank busy with a write", busy_accepts);
        end
        report_test();

        test_name = "random";
        for (int c = 0; c < 2000; c++) begin
            @(negedge clk);
            if (wr_queue.size() == 0 && $urandom_range(1, 0) == 1) begin
                queue_write(int'($urandom_range(NumRegs - 1, 0)), $urandom);
            end
            for (int p = 0; p < NumPorts; p++) begin
                if (rd_queue[p].size() == 0 && $urandom_range(1, 0) == 1) begin
                    queue_read(p, int'($urandom_range(NumRegs - 1, 0)));
                end
            end
        end
        drain();
        report_test();

        $display("Summary: %0d checks, %0d mismatches, %0d stray, %0d missing, %0d other",
                 checks, mismatches, strays, missing, tb_errors);
        if (mismatches + strays + missing + tb_errors == 0 && checks > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
// Shared macro header lives in logic
+incdir+logic
logic/regfile_pkg.sv
logic/regfile_sram.sv
logic/register_file_bank.sv
logic/bank_read_arbiter.sv
logic/banked_register_file.sv
dv/regfile_checker.sv
dv/tb_banked_register_file.sv

// File: run.sh
#!/bin/sh
# Compile the banked register file testbench with Verilator and run it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_banked_register_file \
    -Mdir obj_dir \
    -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
